// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= lanzonesTb
FILELIST  ?= sources.f
LOG       ?= sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "TEST OK" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: sources.f
verilog/coreDefs.sv
verilog/fetchStage.sv
verilog/decodeStage.sv
verilog/regFile.sv
verilog/executeStage.sv
verilog/lanzonesCore.sv
verif/tbMemory.sv
verif/lanzonesTb.sv

// File: verif/lanzonesTb.sv
module lanzonesTb import coreDefs::*; ();

   localparam int unsigned SEED            = 32'h3439_d901;
   localparam word_t       RESET_PC        = 32'd4;
   localparam word_t       DATA_BASE       = 32'd64;   // Set into x10 by the first word
   localparam int          NUM_ROWS        = 15;
   localparam int          PROG_WORDS      = 2 * NUM_ROWS + 2;
   localparam int          CYCLES_PER_WORD = 20;

   // One instruction, then SW rd, row(x10) and the value that store must carry
   typedef struct packed {
      word_t    opWord;
      regAddr_t rd;
      word_t    expData;
   } step_t;

   localparam step_t STEPS [NUM_ROWS] = '{
      '{32'hFFB0_0093, 5'd1,  32'hFFFF_FFFB},   // ADDI x1, x0, -5
      '{32'h0F00_C113, 5'd2,  32'hFFFF_FF0B},   // XORI x2, x1, 0x0F0
      '{32'h1230_6193, 5'd3,  32'h0000_0123},   // ORI  x3, x0, 0x123
      '{32'h0FF0_F213, 5'd4,  32'h0000_00FB},   // ANDI x4, x1, 0x0FF
      '{32'h1234_52B7, 5'd5,  32'h1234_5000},   // LUI  x5, 0x12345
      '{32'h0051_8333, 5'd6,  32'h1234_5123},   // ADD  x6, x3, x5
      '{32'h4011_83B3, 5'd7,  32'h0000_0128},   // SUB  x7, x3, x1
      '{32'h0030_C433, 5'd8,  32'hFFFF_FED8},   // XOR  x8, x1, x3
      '{32'h0032_64B3, 5'd9,  32'h0000_01FB},   // OR   x9, x4, x3
      '{32'h0041_95B3, 5'd11, 32'h1800_0000},   // SLL  x11, x3, x4 (shift 27)
      '{32'h0042_9693, 5'd13, 32'h2345_0000},   // SLLI x13, x5, 4
      '{32'h0040_D713, 5'd14, 32'h0FFF_FFFF},   // SRLI x14, x1, 4
      '{32'h4020_D793, 5'd15, 32'hFFFF_FFFE},   // SRAI x15, x1, 2
      '{32'h0005_2803, 5'd16, 32'hFFFF_FFFB},   // LW   x16, 0(x10)
      '{32'h0070_0013, 5'd0,  32'h0000_0000}    // ADDI x0, x0, 7
   };

   logic  clk;
   logic  rstn;
   logic  LEn;
   logic  RVld;
   word_t RData;
   word_t RWData;
   logic  RWEn;
   logic  RRdy;
   word_t RAddr;
   logic  Halt;

   lanzonesCore #(.ResetPc(RESET_PC)) u_dut (.*);

   tbMemory #(.Seed(SEED)) u_mem (.clk, .RRdy, .RAddr, .RWEn, .RWData, .RVld, .RData);

   always #5 clk = ~clk;

   function automatic word_t encodeStore(input regAddr_t rs2, input logic [11:0] ofs);
      return {ofs[11:5], rs2, 5'd10, 3'b010, ofs[4:0], 7'b0100011};   // Base x10
   endfunction

   task automatic checkValue(input string name, input word_t got, input word_t exp);
      if (got !== exp) begin
         $display("ERR t=%0t %s got %h expected %h", $time, name, got, exp);
         $display("TEST FAILED");
         $fatal(1, "mismatch on %s", name);
      end
   endtask

   task automatic nextCycle();
      @(posedge clk);
      #1;
   endtask

   initial begin
      clk  = 1'b0;
      rstn = 1'b0;
      LEn  = 1'b0;
      nextCycle();
      u_mem.loadWord(RESET_PC, 32'h0400_0513);   // ADDI x10, x0, 64
      for (int i = 0; i < NUM_ROWS; i++) begin
         u_mem.loadWord(RESET_PC + 1 + 2 * i, STEPS[i].opWord);
         u_mem.loadWord(RESET_PC + 2 + 2 * i, encodeStore(STEPS[i].rd, 12'(i)));
      end
      u_mem.loadWord(RESET_PC + PROG_WORDS - 1, 32'hFFFF_FFFF);   // Halt opcode
      repeat (3) nextCycle();
      rstn = 1'b1;
      repeat (3) begin
         nextCycle();
         checkValue("Halt", word_t'(Halt), 1);
         checkValue("RRdy", word_t'(RRdy), 0);
         checkValue("RWEn", word_t'(RWEn), 0);
      end
      LEn = 1'b1;
      nextCycle();
      LEn = 1'b0;
      while (!RRdy) nextCycle();
      checkValue("RAddr", RAddr, RESET_PC);
      while (!Halt) nextCycle();
      repeat (8) begin
         nextCycle();
         checkValue("RRdy", word_t'(RRdy), 0);   // Nothing fetched after halt
      end
      checkValue("store count", word_t'(u_mem.storeAddr.size()), NUM_ROWS);
      for (int i = 0; i < NUM_ROWS; i++) begin
         checkValue($sformatf("RAddr of store %0d", i), u_mem.storeAddr[i], DATA_BASE + i);
         checkValue($sformatf("RWData of store %0d", i), u_mem.storeData[i], STEPS[i].expData);
      end
      $display("TEST OK");
      $finish;
   end

   initial begin
      repeat (CYCLES_PER_WORD * PROG_WORDS) @(posedge clk);
      $display("Watchdog expired, core did not halt within %0d cycles",
               CYCLES_PER_WORD * PROG_WORDS);
      $display("TEST FAILED");
      $fatal(1, "timeout");
   end

endmodule

// File: verif/tbMemory.sv
module tbMemory import coreDefs::*; #(
   parameter int unsigned Seed     = 1,
   parameter int          MemWords = 128
) (
   input  logic  clk,
   input  logic  RRdy,
   input  word_t RAddr,
   input  logic  RWEn,
   input  word_t RWData,
   output logic  RVld,
   output word_t RData
);

   localparam int AW = $clog2(MemWords);

   word_t mem [MemWords];
   word_t storeAddr [$];
   word_t storeData [$];
   int    latency;

   task automatic loadWord(input word_t addr, input word_t data);
      mem[addr[AW-1:0]] = data;
   endtask

   initial begin
      for (int i = 0; i < MemWords; i++) begin
         mem[i[AW-1:0]] = word_t'(i) ^ 32'h5A5A_0000;   // Unwritten words differ per address
      end
      RVld  = 1'b0;
      RData = '0;
      void'($urandom(Seed));
      forever begin
         @(posedge clk);
         #1;
         RVld = 1'b0;
         if (RRdy) begin
            latency = $urandom_range(4, 1);
            repeat (latency) @(posedge clk);
            #1;
            if (RWEn) begin
               mem[RAddr[AW-1:0]] = RWData;
               storeAddr.push_back(RAddr);
               storeData.push_back(RWData);
            end else begin
               RData = mem[RAddr[AW-1:0]];
            end
            RVld = 1'b1;   // Single cycle strobe
         end
      end
   end

endmodule

// File: verilog/coreDefs.sv
package coreDefs;

   localparam int XLEN       = 32;
   localparam int REG_ADDR_W = 5;

   typedef logic [XLEN-1:0]       word_t;
   typedef logic [REG_ADDR_W-1:0] regAddr_t;

   typedef enum logic [6:0] {
      OP_IMM   = 7'b0010011,
      OP_LUI   = 7'b0110111,
      OP_REG   = 7'b0110011,
      OP_STORE = 7'b0100011,
      OP_LOAD  = 7'b0000011,
      OP_HALT  = 7'b1111111
   } opcode_t;

   // Instruction formats, all views of the same word
   typedef union packed {
      struct packed {
         logic [6:0] funct7;
         regAddr_t   rs2;
         regAddr_t   rs1;
         logic [2:0] funct3;
         regAddr_t   rd;
         logic [6:0] opcode;
      } rFmt;
      struct packed {
         logic [11:0] imm12;
         regAddr_t    rs1;
         logic [2:0]  funct3;
         regAddr_t    rd;
         logic [6:0]  opcode;
      } iFmt;
      struct packed {
         logic [6:0] immHi;
         regAddr_t   rs2;
         regAddr_t   rs1;
         logic [2:0] funct3;
         logic [4:0] immLo;
         logic [6:0] opcode;
      } sFmt;
      struct packed {
         logic [19:0] imm20;
         regAddr_t    rd;
         logic [6:0]  opcode;
      } uFmt;
   } instrWord_t;

   typedef enum logic [3:0] {
      ALU_ADD, ALU_SUB, ALU_XOR, ALU_OR, ALU_AND,
      ALU_SLL, ALU_SRL, ALU_SRA, ALU_PASSB
   } aluOp_t;

   typedef struct packed {
      logic     valid;
      aluOp_t   aluOp;
      logic     useImm;
      word_t    imm;      // Final operand B, LUI already shifted
      regAddr_t rs1;
      regAddr_t rs2;
      regAddr_t rd;
      logic     writesRd;
      logic     isLoad;
      logic     isStore;
   } decodedOp_t;

endpackage

// File: verilog/decodeStage.sv
module decodeStage import coreDefs::*; (
   input  instrWord_t instr,
   input  logic       instrValid,
   output decodedOp_t decoded,
   output logic       haltReq
);

   word_t iImm;
   word_t sImm;
   word_t shamt;
   word_t uImm;

   assign iImm  = {{(XLEN-12){instr.iFmt.imm12[11]}}, instr.iFmt.imm12};
   assign sImm  = {{(XLEN-12){instr.sFmt.immHi[6]}}, instr.sFmt.immHi, instr.sFmt.immLo};
   assign shamt = {{(XLEN-REG_ADDR_W){1'b0}}, instr.rFmt.rs2};   // Bits 24:20
   assign uImm  = {instr.uFmt.imm20, 12'h000};

   always_comb begin
      decoded       = '0;
      haltReq       = 1'b0;
      decoded.valid = instrValid;
      if (instrValid) begin
         case (opcode_t'(instr.rFmt.opcode))
            OP_IMM: begin
               decoded.rs1      = instr.iFmt.rs1;
               decoded.rd       = instr.iFmt.rd;
               decoded.writesRd = 1'b1;
               decoded.useImm   = 1'b1;
               decoded.imm      = iImm;
               case (instr.iFmt.funct3)
                  3'b000: decoded.aluOp = ALU_ADD;
                  3'b001: begin
                     decoded.aluOp = ALU_SLL;
                     decoded.imm   = shamt;
                  end
                  3'b101: begin
                     // Anything but the SRAI funct7 shifts logically
                     decoded.aluOp = (instr.rFmt.funct7 == 7'b0100000) ? ALU_SRA : ALU_SRL;
                     decoded.imm   = shamt;
                  end
                  3'b100: decoded.aluOp = ALU_XOR;
                  3'b111: decoded.aluOp = ALU_AND;
                  default: decoded.aluOp = ALU_OR;   // ORI and unknown funct3
               endcase
            end
            OP_LUI: begin
               decoded.rd       = instr.uFmt.rd;
               decoded.writesRd = 1'b1;
               decoded.useImm   = 1'b1;
               decoded.imm      = uImm;
               decoded.aluOp    = ALU_PASSB;
            end
            OP_REG: begin
               decoded.rs1      = instr.rFmt.rs1;
               decoded.rs2      = instr.rFmt.rs2;
               decoded.rd       = instr.rFmt.rd;
               decoded.writesRd = 1'b1;
               decoded.aluOp    = ALU_ADD;   // Fallback for unknown encodings
               if (instr.rFmt.funct7 == 7'b0100000) begin
                  decoded.aluOp = ALU_SUB;
               end else if (instr.rFmt.funct7 == 7'b0000000) begin
                  case (instr.rFmt.funct3)
                     3'b100: decoded.aluOp = ALU_XOR;
                     3'b110: decoded.aluOp = ALU_OR;
                     3'b001: decoded.aluOp = ALU_SLL;
                     default: decoded.aluOp = ALU_ADD;
                  endcase
               end
            end
            OP_STORE: begin
               decoded.rs1     = instr.sFmt.rs1;
               decoded.rs2     = instr.sFmt.rs2;
               decoded.useImm  = 1'b1;
               decoded.imm     = sImm;
               decoded.aluOp   = ALU_ADD;
               decoded.isStore = 1'b1;
            end
            OP_LOAD: begin
               // Every load funct3 is treated as LW
               decoded.rs1      = instr.iFmt.rs1;
               decoded.rd       = instr.iFmt.rd;
               decoded.useImm   = 1'b1;
               decoded.imm      = iImm;
               decoded.aluOp    = ALU_ADD;
               decoded.writesRd = 1'b1;
               decoded.isLoad   = 1'b1;
            end
            OP_HALT: haltReq = 1'b1;
            default: ;
         endcase
      end
   end

endmodule

// File: verilog/executeStage.sv
module executeStage import coreDefs::*; (
   input  logic       clk,
   input  logic       rstn,
   input  decodedOp_t decoded,
   input  word_t      rsData1,
   input  word_t      rsData2,
   input  logic       memVld,
   input  word_t      memRData,
   output logic       stall,
   output logic       memReq,
   output word_t      memAddr,
   output logic       memWrite,
   output word_t      memWData,
   output logic       wrEn,
   output regAddr_t   wrAddr,
   output word_t      wrData
);

   word_t    opB;
   word_t    aluRes;
   logic     memStart;
   logic     memDone;
   logic     loadDone;
   regAddr_t loadRd;

   assign opB = decoded.useImm ? decoded.imm : rsData2;

   always_comb begin
      case (decoded.aluOp)
         ALU_ADD:   aluRes = rsData1 + opB;
         ALU_SUB:   aluRes = rsData1 - opB;
         ALU_XOR:   aluRes = rsData1 ^ opB;
         ALU_OR:    aluRes = rsData1 | opB;
         ALU_AND:   aluRes = rsData1 & opB;
         ALU_SLL:   aluRes = rsData1 << opB[4:0];
         ALU_SRL:   aluRes = rsData1 >> opB[4:0];
         ALU_SRA:   aluRes = word_t'($signed(rsData1) >>> opB[4:0]);
         ALU_PASSB: aluRes = opB;   // LUI
         default:   aluRes = '0;
      endcase
   end

   assign memStart = decoded.valid && (decoded.isLoad || decoded.isStore);
   assign memDone  = memReq && memVld;
   assign loadDone = memDone && !memWrite;

   // Stall covers the decode cycle and the whole access
   assign stall = memStart || memReq;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         memReq   <= 1'b0;
         memWrite <= 1'b0;
      end else if (memStart) begin
         memReq   <= 1'b1;
         memWrite <= decoded.isStore;
      end else if (memDone) begin
         memReq   <= 1'b0;
         memWrite <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (memStart) begin
         memAddr  <= aluRes;   // rs1 + imm
         memWData <= rsData2;
         loadRd   <= decoded.rd;
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         wrEn <= 1'b0;
      end else begin
         wrEn <= loadDone || (decoded.valid && decoded.writesRd && !decoded.isLoad);
      end
   end

   // Fetch is stalled during a load, so the two sources never meet
   always_ff @(posedge clk) begin
      if (loadDone) begin
         wrAddr <= loadRd;
         wrData <= memRData;
      end else begin
         wrAddr <= decoded.rd;
         wrData <= aluRes;
      end
   end

   // Latched address and data must survive until RVld
   noDecodeInAccess: assert property (@(posedge clk) disable iff (!rstn)
      memReq |-> !decoded.valid)
      else $error("instruction decoded while a memory access is outstanding");

endmodule

// File: verilog/fetchStage.sv
module fetchStage import coreDefs::*; #(
   parameter word_t ResetPc = '0
) (
   input  logic       clk,
   input  logic       rstn,
   input  logic       LEn,
   input  logic       memVld,
   input  word_t      memRData,
   input  logic       stall,
   input  logic       haltReq,
   output logic       fetchReq,
   output word_t      fetchAddr,
   output instrWord_t instr,
   output logic       instrValid,
   output logic       Halt
);

   word_t pc;
   logic  pending;     // Fetch request outstanding
   logic  startFetch;
   logic  fetchDone;

   // Halt request is checked too, so nothing is fetched past the halt word
   assign startFetch = !Halt && !stall && !haltReq && !pending;
   assign fetchDone  = pending && memVld;

   assign fetchReq  = pending;
   assign fetchAddr = pc;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         Halt <= 1'b1;
      end else if (LEn) begin
         Halt <= 1'b0;
      end else if (haltReq) begin
         Halt <= 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         pending    <= 1'b0;
         instrValid <= 1'b0;
         pc         <= ResetPc;
      end else begin
         instrValid <= fetchDone;   // One cycle pulse
         if (fetchDone) begin
            pending <= 1'b0;
            pc      <= pc + word_t'(1);   // Word addressed
         end else if (startFetch) begin
            pending <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (fetchDone) begin
         instr <= memRData;
      end
   end

   // Port is owned by execute during a load or store
   fetchNoStall: assert property (@(posedge clk) disable iff (!rstn)
      !(fetchReq && stall))
      else $error("fetch request raised while execute holds the port");

endmodule

// File: verilog/lanzonesCore.sv
module lanzonesCore import coreDefs::*; #(
   parameter word_t ResetPc = '0
) (
   input  logic  clk,
   input  logic  rstn,
   input  logic  RVld,
   input  word_t RData,
   input  logic  LEn,
   output word_t RWData,
   output logic  RWEn,
   output logic  RRdy,
   output word_t RAddr,
   output logic  Halt
);

   instrWord_t instr;
   logic       instrValid;
   decodedOp_t decoded;
   logic       haltReq;
   word_t      rsData1;
   word_t      rsData2;
   logic       wrEn;
   regAddr_t   wrAddr;
   word_t      wrData;
   logic       stall;
   logic       fetchReq;
   word_t      fetchAddr;
   logic       memReq;
   word_t      memAddr;
   logic       memWrite;
   word_t      memWData;

   fetchStage #(.ResetPc(ResetPc)) uFetch (
      .clk, .rstn, .LEn, .memVld(RVld), .memRData(RData), .stall, .haltReq,
      .fetchReq, .fetchAddr, .instr, .instrValid, .Halt
   );

   decodeStage uDecode (.instr, .instrValid, .decoded, .haltReq);

   regFile uRegFile (
      .clk, .rstn, .rs1(decoded.rs1), .rs2(decoded.rs2),
      .wrEn, .wrAddr, .wrData, .rsData1, .rsData2
   );

   executeStage uExecute (
      .clk, .rstn, .decoded, .rsData1, .rsData2, .memVld(RVld), .memRData(RData),
      .stall, .memReq, .memAddr, .memWrite, .memWData, .wrEn, .wrAddr, .wrData
   );

   // Execute owns the port while stalled
   assign RRdy   = stall ? memReq : fetchReq;
   assign RAddr  = stall ? memAddr : fetchAddr;
   assign RWEn   = stall && memWrite;
   assign RWData = stall ? memWData : '0;

endmodule

// File: verilog/regFile.sv
module regFile import coreDefs::*; (
   input  logic     clk,
   input  logic     rstn,
   input  regAddr_t rs1,
   input  regAddr_t rs2,
   input  logic     wrEn,
   input  regAddr_t wrAddr,
   input  word_t    wrData,
   output word_t    rsData1,
   output word_t    rsData2
);

   localparam int NUM_REGS = 2**REG_ADDR_W;

   word_t regs [NUM_REGS];

   always_ff @(posedge clk) begin
      if (!rstn) begin
         for (int i = 0; i < NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (wrEn && wrAddr != '0) begin   // x0 stays zero
         regs[wrAddr] <= wrData;
      end
   end

   assign rsData1 = regs[rs1];
   assign rsData2 = regs[rs2];

   // No bypass, the write must land before the next decode reads
   noReadOfPendingWrite: assert property (@(posedge clk) disable iff (!rstn)
      (wrEn && wrAddr != '0) |-> (rs1 != wrAddr && rs2 != wrAddr))
      else $error("register read while its writeback is still pending");

endmodule
